/* source/pipe_pkg.sv */
// widths, opcode and memory-code enums, stage payload structs, SRAM depth
`default_nettype none

package pipe_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int mem_words  = 256;
    localparam int mem_addr_w = 8;

    // shift amounts take the low 5 bits of operand b
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_slt    = 4'd7,
        alu_pass_b = 4'd8
    } alu_op_t;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_read  = 2'd1,
        mem_write = 2'd2
    } mem_rw_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       sext_imm;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        alu_op_t               alu_op;
        logic [reg_addr_w-1:0] rd;
        logic                  rd_write;
        // pc instead of rs1
        logic                  alu_src_a;
        // immediate instead of rs2
        logic                  alu_src_b;
        mem_rw_t               mem_rw;
    } id_ex_t;

    // result carries the byte address for loads and stores
    typedef struct packed {
        logic [xlen-1:0]       result;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] rd;
        logic                  rd_write;
        mem_rw_t               mem_rw;
    } ex_mem_t;

endpackage

`default_nettype wire

/* source/mem_bus_if.sv */
// memory bus interface for one SRAM requester, requester and arbiter modports
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
    import pipe_pkg::*;

    logic                  req;
    logic                  we;
    // word address
    logic [mem_addr_w-1:0] addr;
    logic [xlen-1:0]       wdata;
    logic                  gnt;
    // valid the cycle after gnt
    logic [xlen-1:0]       rdata;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

/* source/pipe_reg.sv */
// valid/ready pipeline register, payload chosen by type parameter
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic clk,
    input  wire logic reset,

    input  wire logic in_valid_i,
    output logic      in_ready_o,
    input  payload_t  in_data_i,

    output logic      out_valid_o,
    input  wire logic out_ready_i,
    output payload_t  out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // empty, or the held item leaves this cycle
    assign in_ready_o  = !valid_q || out_ready_i;
    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            data_q  <= '0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
            if (in_valid_i) begin
                data_q <= in_data_i;
            end
        end
    end

endmodule

`default_nettype wire

/* source/exec_unit.sv */
// operand select, ALU and effective address for the execute/memory payload
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  pipe_pkg::id_ex_t  id_ex_i,
    output pipe_pkg::ex_mem_t ex_mem_o
);
    import pipe_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic            less;
    logic [xlen-1:0] alu_result;

    assign op_a  = id_ex_i.alu_src_a ? id_ex_i.pc : id_ex_i.rs1_data;
    assign op_b  = id_ex_i.alu_src_b ? id_ex_i.sext_imm : id_ex_i.rs2_data;
    assign shamt = op_b[4:0];
    assign less  = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (id_ex_i.alu_op)
            alu_add:    alu_result = op_a + op_b;
            alu_sub:    alu_result = op_a - op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            alu_sll:    alu_result = op_a << shamt;
            alu_srl:    alu_result = op_a >> shamt;
            alu_slt:    alu_result = {{(xlen-1){1'b0}}, less};
            alu_pass_b: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    always_comb begin
        // loads and stores always add base and offset
        if (id_ex_i.mem_rw != mem_none) begin
            ex_mem_o.result = op_a + op_b;
        end else begin
            ex_mem_o.result = alu_result;
        end
        ex_mem_o.store_data = id_ex_i.rs2_data;
        ex_mem_o.rd         = id_ex_i.rd;
        ex_mem_o.rd_write   = id_ex_i.rd_write;
        ex_mem_o.mem_rw     = id_ex_i.mem_rw;
    end

endmodule

`default_nettype wire

/* source/lsu.sv */
// load/store unit, retires ALU results and does word loads and stores
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  wire logic                        clk,
    input  wire logic                        reset,

    input  wire logic                        in_valid_i,
    output logic                             in_ready_o,
    input  pipe_pkg::ex_mem_t                in_data_i,

    mem_bus_if.requester                     bus,

    output logic                             wb_valid_o,
    output logic [pipe_pkg::reg_addr_w-1:0]  wb_rd_o,
    output logic [pipe_pkg::xlen-1:0]        wb_data_o
);
    import pipe_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_gnt,
        st_wait_data
    } lsu_state_t;

    lsu_state_t            state_q;
    lsu_state_t            state_d;
    logic                  mem_op;
    logic                  issue;
    logic [reg_addr_w-1:0] load_rd_q;
    logic                  load_wr_q;

    assign mem_op = in_data_i.mem_rw != mem_none;
    assign issue  = (state_q != st_wait_data) && in_valid_i && mem_op;

    // request comes straight from the held ex_mem item
    assign bus.req   = issue;
    assign bus.we    = in_data_i.mem_rw == mem_write;
    assign bus.addr  = in_data_i.result[mem_addr_w+1:2];
    assign bus.wdata = in_data_i.store_data;

    // a memory item leaves ex_mem only at its grant
    assign in_ready_o = (state_q != st_wait_data) && (!in_valid_i || !mem_op || bus.gnt);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle, st_wait_gnt: begin
                if (issue) begin
                    if (!bus.gnt) begin
                        state_d = st_wait_gnt;
                    end else if (in_data_i.mem_rw == mem_read) begin
                        state_d = st_wait_data;
                    end else begin
                        state_d = st_idle;
                    end
                end
            end
            st_wait_data: state_d = st_idle;
            default:      state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= st_idle;
            wb_valid_o <= 1'b0;
        end else begin
            state_q    <= state_d;
            wb_valid_o <= 1'b0;
            if (state_q == st_wait_data) begin
                wb_valid_o <= load_wr_q;
            end else if (in_valid_i && !mem_op) begin
                wb_valid_o <= in_data_i.rd_write;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue && bus.gnt) begin
            load_rd_q <= in_data_i.rd;
            load_wr_q <= in_data_i.rd_write;
        end
        if (state_q == st_wait_data) begin
            wb_rd_o   <= load_rd_q;
            wb_data_o <= bus.rdata;
        end else if (in_valid_i && !mem_op) begin
            wb_rd_o   <= in_data_i.rd;
            wb_data_o <= in_data_i.result;
        end
    end

endmodule

`default_nettype wire

/* source/host_port.sv */
// host access port, one bus transaction per held host request
`timescale 1ns/1ps
`default_nettype none

module host_port (
    input  wire logic                  clk,
    input  wire logic                  reset,

    input  wire logic                  host_req_i,
    input  wire logic                  host_we_i,
    input  wire logic [pipe_pkg::xlen-1:0] host_addr_i,
    input  wire logic [pipe_pkg::xlen-1:0] host_wdata_i,
    output logic                       host_done_o,
    output logic [pipe_pkg::xlen-1:0]  host_rdata_o,

    mem_bus_if.requester               bus
);
    import pipe_pkg::*;

    typedef enum logic [1:0] {
        h_idle,
        h_req,
        h_data,
        h_release
    } host_state_t;

    host_state_t           state_q;
    logic                  we_q;
    logic [mem_addr_w-1:0] addr_q;
    logic [xlen-1:0]       wdata_q;

    assign bus.req   = state_q == h_req;
    assign bus.we    = we_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= h_idle;
            host_done_o <= 1'b0;
        end else begin
            host_done_o <= 1'b0;
            case (state_q)
                h_idle: begin
                    if (host_req_i) begin
                        state_q <= h_req;
                    end
                end
                h_req: begin
                    if (bus.gnt) begin
                        if (we_q) begin
                            host_done_o <= 1'b1;
                            state_q     <= h_release;
                        end else begin
                            state_q <= h_data;
                        end
                    end
                end
                h_data: begin
                    host_done_o <= 1'b1;
                    state_q     <= h_release;
                end
                // wait for the host to drop its request
                h_release: begin
                    if (!host_req_i) begin
                        state_q <= h_idle;
                    end
                end
                default: state_q <= h_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == h_idle && host_req_i) begin
            we_q    <= host_we_i;
            addr_q  <= host_addr_i[mem_addr_w+1:2];
            wdata_q <= host_wdata_i;
        end
        if (state_q == h_data) begin
            host_rdata_o <= bus.rdata;
        end
    end

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
// fixed-priority SRAM arbiter, lsu over host, with read data return
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire logic                         clk,
    input  wire logic                         reset,

    mem_bus_if.arbiter                        lsu_bus,
    mem_bus_if.arbiter                        host_bus,

    output logic                              sram_en_o,
    output logic                              sram_we_o,
    output logic [pipe_pkg::mem_addr_w-1:0]   sram_addr_o,
    output logic [pipe_pkg::xlen-1:0]         sram_wdata_o,
    input  wire logic [pipe_pkg::xlen-1:0]    sram_rdata_i
);

    logic host_win;
    logic lsu_sel_q;
    logic host_sel_q;

    // host only gets a cycle the lsu leaves idle
    assign host_win     = host_bus.req && !lsu_bus.req;
    assign lsu_bus.gnt  = lsu_bus.req;
    assign host_bus.gnt = host_win;

    assign sram_en_o    = lsu_bus.req || host_bus.req;
    assign sram_we_o    = lsu_bus.req ? lsu_bus.we    : host_bus.we;
    assign sram_addr_o  = lsu_bus.req ? lsu_bus.addr  : host_bus.addr;
    assign sram_wdata_o = lsu_bus.req ? lsu_bus.wdata : host_bus.wdata;

    // winner of the previous cycle owns this cycle's read data
    always_ff @(posedge clk) begin
        if (reset) begin
            lsu_sel_q  <= 1'b0;
            host_sel_q <= 1'b0;
        end else begin
            lsu_sel_q  <= lsu_bus.req;
            host_sel_q <= host_win;
        end
    end

    assign lsu_bus.rdata  = lsu_sel_q  ? sram_rdata_i : '0;
    assign host_bus.rdata = host_sel_q ? sram_rdata_i : '0;

endmodule

`default_nettype wire

/* source/data_sram.sv */
// single-port word SRAM with registered read
`timescale 1ns/1ps
`default_nettype none

module data_sram (
    input  wire logic                        clk,
    input  wire logic                        en_i,
    input  wire logic                        we_i,
    input  wire logic [pipe_pkg::mem_addr_w-1:0] addr_i,
    input  wire logic [pipe_pkg::xlen-1:0]   wdata_i,
    output logic [pipe_pkg::xlen-1:0]        rdata_o
);
    import pipe_pkg::*;

    logic [xlen-1:0] mem [mem_words];

    // read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

/* source/exe_mem_top.sv */
// execute/memory back end top level with plain ports
`timescale 1ns/1ps
`default_nettype none

module exe_mem_top (
    input  wire logic                            clk,
    input  wire logic                            reset,

    input  wire logic                            op_valid_i,
    output logic                                 op_ready_o,
    input  wire logic [pipe_pkg::xlen-1:0]       op_pc_i,
    input  wire logic [pipe_pkg::xlen-1:0]       op_imm_i,
    input  wire logic [pipe_pkg::xlen-1:0]       op_rs1_i,
    input  wire logic [pipe_pkg::xlen-1:0]       op_rs2_i,
    input  pipe_pkg::alu_op_t                    op_alu_op_i,
    input  wire logic [pipe_pkg::reg_addr_w-1:0] op_rd_i,
    input  wire logic                            op_rd_write_i,
    input  wire logic                            op_src_a_i,
    input  wire logic                            op_src_b_i,
    input  pipe_pkg::mem_rw_t                    op_mem_rw_i,

    output logic                                 wb_valid_o,
    output logic [pipe_pkg::reg_addr_w-1:0]      wb_rd_o,
    output logic [pipe_pkg::xlen-1:0]            wb_data_o,

    input  wire logic                            host_req_i,
    input  wire logic                            host_we_i,
    input  wire logic [pipe_pkg::xlen-1:0]       host_addr_i,
    input  wire logic [pipe_pkg::xlen-1:0]       host_wdata_i,
    output logic                                 host_done_o,
    output logic [pipe_pkg::xlen-1:0]            host_rdata_o
);
    import pipe_pkg::*;

    id_ex_t                id_ex_in;
    id_ex_t                id_ex_q;
    logic                  id_ex_valid;
    logic                  ex_mem_ready;
    ex_mem_t               ex_mem_in;
    ex_mem_t               ex_mem_q;
    logic                  ex_mem_valid;
    logic                  lsu_ready;
    logic                  sram_en;
    logic                  sram_we;
    logic [mem_addr_w-1:0] sram_addr;
    logic [xlen-1:0]       sram_wdata;
    logic [xlen-1:0]       sram_rdata;

    mem_bus_if lsu_bus ();
    mem_bus_if host_bus ();

    always_comb begin
        id_ex_in.pc        = op_pc_i;
        id_ex_in.sext_imm  = op_imm_i;
        id_ex_in.rs1_data  = op_rs1_i;
        id_ex_in.rs2_data  = op_rs2_i;
        id_ex_in.alu_op    = op_alu_op_i;
        id_ex_in.rd        = op_rd_i;
        id_ex_in.rd_write  = op_rd_write_i;
        id_ex_in.alu_src_a = op_src_a_i;
        id_ex_in.alu_src_b = op_src_b_i;
        id_ex_in.mem_rw    = op_mem_rw_i;
    end

    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk(clk), .reset(reset),
        .in_valid_i(op_valid_i), .in_ready_o(op_ready_o), .in_data_i(id_ex_in),
        .out_valid_o(id_ex_valid), .out_ready_i(ex_mem_ready), .out_data_o(id_ex_q)
    );

    exec_unit exec_unit_inst (
        .id_ex_i(id_ex_q),
        .ex_mem_o(ex_mem_in)
    );

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk(clk), .reset(reset),
        .in_valid_i(id_ex_valid), .in_ready_o(ex_mem_ready), .in_data_i(ex_mem_in),
        .out_valid_o(ex_mem_valid), .out_ready_i(lsu_ready), .out_data_o(ex_mem_q)
    );

    lsu lsu_inst (
        .clk(clk), .reset(reset),
        .in_valid_i(ex_mem_valid), .in_ready_o(lsu_ready), .in_data_i(ex_mem_q),
        .bus(lsu_bus.requester),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

    host_port host_port_inst (
        .clk(clk), .reset(reset),
        .host_req_i(host_req_i), .host_we_i(host_we_i),
        .host_addr_i(host_addr_i), .host_wdata_i(host_wdata_i),
        .host_done_o(host_done_o), .host_rdata_o(host_rdata_o),
        .bus(host_bus.requester)
    );

    mem_arbiter mem_arbiter_inst (
        .clk(clk), .reset(reset),
        .lsu_bus(lsu_bus.arbiter), .host_bus(host_bus.arbiter),
        .sram_en_o(sram_en), .sram_we_o(sram_we), .sram_addr_o(sram_addr),
        .sram_wdata_o(sram_wdata), .sram_rdata_i(sram_rdata)
    );

    data_sram data_sram_inst (
        .clk(clk), .en_i(sram_en), .we_i(sram_we), .addr_i(sram_addr),
        .wdata_i(sram_wdata), .rdata_o(sram_rdata)
    );

endmodule

`default_nettype wire

/* bench/pipe_assertions.sv */
// bound concurrent assertions on the memory bus handshakes, arbiter and writeback reset
`timescale 1ns/1ps
`default_nettype none

module pipe_assertions (
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        lsu_req_i,
    input wire logic        lsu_we_i,
    input wire logic [7:0]  lsu_addr_i,
    input wire logic [31:0] lsu_wdata_i,
    input wire logic        lsu_gnt_i,
    input wire logic        host_req_i,
    input wire logic        host_gnt_i,
    input wire logic        wb_valid_i
);

    // one SRAM, one winner per cycle
    grant_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(lsu_gnt_i && host_gnt_i))
        else $error("lsu and host grants high in the same cycle");

    lsu_grant_needs_req: assert property (@(posedge clk) disable iff (reset)
        lsu_gnt_i |-> lsu_req_i)
        else $error("lsu grant without an lsu request");

    host_grant_needs_req: assert property (@(posedge clk) disable iff (reset)
        host_gnt_i |-> host_req_i)
        else $error("host grant without a host request");

    lsu_req_held: assert property (@(posedge clk) disable iff (reset)
        (lsu_req_i && !lsu_gnt_i) |=>
            (lsu_req_i && $stable(lsu_we_i) && $stable(lsu_addr_i) && $stable(lsu_wdata_i)))
        else $error("lsu request changed before its grant");

    wb_quiet_in_reset: assert property (@(posedge clk)
        reset |=> !wb_valid_i)
        else $error("writeback valid after a reset cycle");

endmodule

bind exe_mem_top pipe_assertions pipe_assertions_inst (
    .clk(clk),
    .reset(reset),
    .lsu_req_i(lsu_bus.req),
    .lsu_we_i(lsu_bus.we),
    .lsu_addr_i(lsu_bus.addr),
    .lsu_wdata_i(lsu_bus.wdata),
    .lsu_gnt_i(lsu_bus.gnt),
    .host_req_i(host_bus.req),
    .host_gnt_i(host_bus.gnt),
    .wb_valid_i(wb_valid_o)
);

`default_nettype wire

/* bench/tb_exe_mem_top.sv */
// testbench for exe_mem_top, random stimulus with a writeback and memory model
`timescale 1ns/1ps
`default_nettype none

module tb_exe_mem_top;
    import pipe_pkg::*;

    logic        clk;
    logic        reset;
    logic        op_valid_i;
    logic        op_ready_o;
    logic [31:0] op_pc_i;
    logic [31:0] op_imm_i;
    logic [31:0] op_rs1_i;
    logic [31:0] op_rs2_i;
    alu_op_t     op_alu_op_i;
    logic [4:0]  op_rd_i;
    logic        op_rd_write_i;
    logic        op_src_a_i;
    logic        op_src_b_i;
    mem_rw_t     op_mem_rw_i;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;
    logic        host_req_i;
    logic        host_we_i;
    logic [31:0] host_addr_i;
    logic [31:0] host_wdata_i;
    logic        host_done_o;
    logic [31:0] host_rdata_o;

    integer      seed;
    int          errors;
    int          checks;
    int          test_start;
    int          exp_count;
    int          wb_count;
    logic [4:0]  exp_rd_q[$];
    logic [31:0] exp_data_q[$];
    logic [31:0] mem_model [256];
    logic [31:0] mon_a;
    logic [31:0] mon_b;
    logic [31:0] mon_sum;
    logic [31:0] haddr;
    logic [31:0] hdata;
    logic [31:0] host_data;
    logic [31:0] op_addr;
    logic [31:0] stored_addr [8];

    exe_mem_top exe_mem_top_inst (
        .clk(clk), .reset(reset),
        .op_valid_i(op_valid_i), .op_ready_o(op_ready_o),
        .op_pc_i(op_pc_i), .op_imm_i(op_imm_i), .op_rs1_i(op_rs1_i), .op_rs2_i(op_rs2_i),
        .op_alu_op_i(op_alu_op_i), .op_rd_i(op_rd_i), .op_rd_write_i(op_rd_write_i),
        .op_src_a_i(op_src_a_i), .op_src_b_i(op_src_b_i), .op_mem_rw_i(op_mem_rw_i),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
        .host_req_i(host_req_i), .host_we_i(host_we_i), .host_addr_i(host_addr_i),
        .host_wdata_i(host_wdata_i), .host_done_o(host_done_o), .host_rdata_o(host_rdata_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] expected_alu(input logic [3:0] code,
                                                 input logic [31:0] a, input logic [31:0] b);
        case (code)
            alu_add:    return a + b;
            alu_sub:    return a - b;
            alu_and:    return a & b;
            alu_or:     return a | b;
            alu_xor:    return a ^ b;
            alu_sll:    return a << b[4:0];
            alu_srl:    return a >> b[4:0];
            alu_slt:    return {31'd0, $signed(a) < $signed(b)};
            alu_pass_b: return b;
            default:    return 32'd0;
        endcase
    endfunction

    // checks each writeback in order and records each accepted operation
    always @(posedge clk) begin
        if (!reset) begin
            if (wb_valid_o) begin
                wb_count++;
                checks++;
                if (exp_rd_q.size() == 0) begin
                    $display("writeback at %0t arrived with no operation outstanding", $time);
                    errors++;
                end else if (wb_rd_o !== exp_rd_q[0] || wb_data_o !== exp_data_q[0]) begin
                    $display("[FAIL] %0t: writeback rd %0d data %h, expected rd %0d data %h",
                             $time, wb_rd_o, wb_data_o, exp_rd_q[0], exp_data_q[0]);
                    errors++;
                end
                if (exp_rd_q.size() != 0) begin
                    void'(exp_rd_q.pop_front());
                    void'(exp_data_q.pop_front());
                end
            end
            if (op_valid_i && op_ready_o) begin
                mon_a   = op_src_a_i ? op_pc_i : op_rs1_i;
                mon_b   = op_src_b_i ? op_imm_i : op_rs2_i;
                mon_sum = mon_a + mon_b;
                if (op_mem_rw_i == mem_write) begin
                    mem_model[mon_sum[9:2]] = op_rs2_i;
                end else if (op_rd_write_i) begin
                    exp_rd_q.push_back(op_rd_i);
                    if (op_mem_rw_i == mem_read) begin
                        exp_data_q.push_back(mem_model[mon_sum[9:2]]);
                    end else begin
                        exp_data_q.push_back(expected_alu(op_alu_op_i, mon_a, mon_b));
                    end
                    exp_count++;
                end
            end
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("Some tests failed");
        $finish;
    endtask

    // called on a rising edge and returns on the accepting edge
    task automatic send_op(input logic [3:0] code, input mem_rw_t rw, input logic src_a,
                           input logic src_b, input logic rd_wr, input logic [4:0] rd,
                           input logic [31:0] imm, input logic [31:0] rs1,
                           input logic [31:0] rs2);
        int waited;
        waited = 0;
        op_valid_i    <= 1'b1;
        op_alu_op_i   <= alu_op_t'(code);
        op_mem_rw_i   <= rw;
        op_src_a_i    <= src_a;
        op_src_b_i    <= src_b;
        op_rd_write_i <= rd_wr;
        op_rd_i       <= rd;
        op_pc_i       <= $random(seed);
        op_imm_i      <= imm;
        op_rs1_i      <= rs1;
        op_rs2_i      <= rs2;
        @(posedge clk);
        while (!op_ready_o) begin
            waited++;
            if (waited > 500) abort_on_timeout("op_ready_o stayed low");
            @(posedge clk);
        end
    endtask

    task automatic idle_ops(input int cycles);
        op_valid_i <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic send_alu();
        logic [3:0] code;
        logic [2:0] bits;
        code = 4'({$random(seed)} % 9);
        bits = $random(seed);
        send_op(code, mem_none, bits[0], bits[1], bits[2], 5'($random(seed)),
                $random(seed), $random(seed), $random(seed));
    endtask

    // base plus offset lands on byte_addr for any alu opcode
    task automatic send_mem(input logic is_store, input logic [31:0] byte_addr);
        logic [31:0] off;
        logic [3:0]  code;
        off  = $random(seed) & 32'h0fc;
        code = 4'({$random(seed)} % 9);
        send_op(code, is_store ? mem_write : mem_read, 1'b0, 1'b1, !is_store,
                5'($random(seed)), off, byte_addr - off, $random(seed));
    endtask

    task automatic host_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        host_req_i   <= 1'b1;
        host_we_i    <= we;
        host_addr_i  <= addr;
        host_wdata_i <= wdata;
        @(posedge clk);
        while (!host_done_o) begin
            waited++;
            if (waited > 2000) abort_on_timeout("host_done_o never pulsed");
            @(posedge clk);
        end
        rdata = host_rdata_o;
        host_req_i <= 1'b0;
        @(posedge clk);
    endtask

    task automatic host_check_read(input logic [31:0] addr);
        host_access(1'b0, addr, 32'd0, host_data);
        checks++;
        if (host_data !== mem_model[addr[9:2]]) begin
            $display("[FAIL] %0t: host read of %h gave %h, expected %h",
                     $time, addr, host_data, mem_model[addr[9:2]]);
            errors++;
        end
    endtask

    // a trailing load retires only after everything issued before it
    task automatic drain_pipeline();
        int waited;
        waited = 0;
        send_mem(1'b0, 32'd0);
        idle_ops(1);
        while (exp_rd_q.size() != 0) begin
            waited++;
            if (waited > 500) abort_on_timeout("writeback queue never drained");
            @(posedge clk);
        end
        checks++;
        if (wb_count != exp_count) begin
            $display("[FAIL] %0t: %0d writebacks seen, %0d expected", $time, wb_count, exp_count);
            errors++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s finished with %0d errors", num, name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        seed = 92;
        errors = 0;
        checks = 0;
        test_start = 0;
        exp_count = 0;
        wb_count = 0;
        op_valid_i = 1'b0;
        op_pc_i = '0;
        op_imm_i = '0;
        op_rs1_i = '0;
        op_rs2_i = '0;
        op_alu_op_i = alu_add;
        op_rd_i = '0;
        op_rd_write_i = 1'b0;
        op_src_a_i = 1'b0;
        op_src_b_i = 1'b0;
        op_mem_rw_i = mem_none;
        host_req_i = 1'b0;
        host_we_i = 1'b0;
        host_addr_i = '0;
        host_wdata_i = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        for (int i = 0; i < 256; i++) begin
            hdata = $random(seed);
            host_access(1'b1, i * 4, hdata, host_data);
            mem_model[i] = hdata;
        end
        for (int i = 0; i < 256; i++) begin
            host_check_read(((i * 37) % 256) * 4);
        end
        finish_test(1, "host preload and readback");

        for (int i = 0; i < 200; i++) begin
            send_alu();
            if ({$random(seed)} % 4 == 0) idle_ops(1 + {$random(seed)} % 2);
        end
        drain_pipeline();
        finish_test(2, "random alu operations");

        for (int i = 0; i < 64; i++) begin
            op_addr = $random(seed) & 32'h3fc;
            stored_addr[i % 8] = op_addr;
            send_mem(1'b1, op_addr);
            send_mem(1'b0, op_addr);
            send_mem(1'b0, $random(seed) & 32'h3fc);
        end
        drain_pipeline();
        for (int i = 0; i < 8; i++) begin
            host_check_read(stored_addr[i]);
        end
        finish_test(3, "stores and loads");

        for (int i = 0; i < 30; i++) begin
            repeat (1 + {$random(seed)} % 16) begin
                case ({$random(seed)} % 4)
                    0, 1:    send_alu();
                    2:       send_mem(1'b0, $random(seed) & 32'h3fc);
                    default: send_mem(1'b1, $random(seed) & 32'h3fc);
                endcase
            end
            idle_ops({$random(seed)} % 4);
        end
        drain_pipeline();
        finish_test(4, "bursty operation stream");

        // pipeline uses words 0 to 127 and the host words 128 to 255
        fork
            begin : op_stream
                for (int i = 0; i < 150; i++) begin
                    case ({$random(seed)} % 3)
                        0:       send_alu();
                        1:       send_mem(1'b0, $random(seed) & 32'h1fc);
                        default: send_mem(1'b1, $random(seed) & 32'h1fc);
                    endcase
                    if ({$random(seed)} % 3 == 0) idle_ops(1 + {$random(seed)} % 3);
                end
                idle_ops(0);
            end
            begin : host_stream
                for (int j = 0; j < 24; j++) begin
                    haddr = 32'h200 + ($random(seed) & 32'h1fc);
                    if ($random(seed) & 1) begin
                        hdata = $random(seed);
                        host_access(1'b1, haddr, hdata, host_data);
                        mem_model[haddr[9:2]] = hdata;
                    end else begin
                        host_check_read(haddr);
                    end
                    repeat ({$random(seed)} % 8) @(posedge clk);
                end
            end
        join
        drain_pipeline();
        finish_test(5, "host access during lsu traffic");

        $display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
source/pipe_pkg.sv
source/mem_bus_if.sv
source/pipe_reg.sv
source/exec_unit.sv
source/lsu.sv
source/host_port.sv
source/mem_arbiter.sv
source/data_sram.sv
source/exe_mem_top.sv
bench/pipe_assertions.sv
bench/tb_exe_mem_top.sv

/* Bender.yml */
package:
  name: exe_mem

sources:
  - source/pipe_pkg.sv
  - source/mem_bus_if.sv
  - source/pipe_reg.sv
  - source/exec_unit.sv
  - source/lsu.sv
  - source/host_port.sv
  - source/mem_arbiter.sv
  - source/data_sram.sv
  - source/exe_mem_top.sv
  - target: test
    files:
      - bench/pipe_assertions.sv
      - bench/tb_exe_mem_top.sv
